// ==== dv/eth_test_tb.sv ====
/* Testbench for the GMII transmit test subsystem. Random values come from a fixed seed;
   bursts are checked byte for byte against a frame model with its own CRC-32. */
`default_nettype none
`include "eth_test_config.svh"

module eth_test_tb import eth_test_pkg::*;;

	logic                       tx_clk;
	logic                       rst;
	logic                       awvalid;
	logic                       awready;
	logic [`ETH_AXI_ADDR_W-1:0] awaddr;
	logic                       wvalid;
	logic                       wready;
	axi_data_t                  wdata;
	logic [3:0]                 wstrb;
	logic                       bvalid;
	logic                       bready;
	logic [1:0]                 bresp;
	logic                       arvalid;
	logic                       arready;
	logic [`ETH_AXI_ADDR_W-1:0] araddr;
	logic                       rvalid;
	logic                       rready;
	axi_data_t                  rdata;
	logic [1:0]                 rresp;
	byte_t                      gmii_txd;
	logic                       gmii_tx_en;

	integer    seed;
	// Frame parameters drawn up front so the watchdog limit is known
	int        len0;
	int        seed0;
	mac_addr_t mac0;
	int        shot_len [4];
	int        shot_seed [4];
	mac_addr_t shot_mac [4];
	int        cont_len;
	int        cont_seed;
	mac_addr_t cont_mac;
	longint    wd_limit = 0;
	// Bookkeeping per test
	string     cur_test;
	int        err_cnt = 0;
	int        err_base = 0;
	int        n_pass = 0;
	int        n_fail = 0;
	int        exp_done = 0;
	int        val;
	byte_t     exp_q [$];
	// Monitor state
	byte_t     mon_bytes [$];
	int        mon_lens [$];
	int        starts = 0;
	int        done_cnt = 0;
	int        cur_len = 0;
	int        gap_len = 0;
	logic      prev_en = 1'b0;

	eth_test_top i_dut (.*);

	initial begin
		tx_clk = 1'b0;
		forever #5 tx_clk = ~tx_clk;
	end

	function automatic int rand_range(input int lo, input int hi);
		int unsigned r;
		r = $random(seed);
		return lo + int'(r % (hi - lo + 1));
	endfunction

	function automatic mac_addr_t rand_mac();
		logic [63:0] r;
		r = {$random(seed), $random(seed)};
		return r[47:0];
	endfunction

	// Bitwise reflected CRC-32 with the data taken lsb first
	function automatic logic [31:0] crc_update(input logic [31:0] crc, input byte_t d);
		logic [31:0] c;
		logic        fb;
		c = crc;
		for (int b = 0; b < 8; b++) begin
			fb = c[0] ^ d[b];
			c  = {1'b0, c[31:1]};
			if (fb)
				c = c ^ 32'hEDB88320;
		end
		return c;
	endfunction

	// Expected wire bytes from the preamble up to the FCS, which goes low byte first
	task automatic build_frame(input int len, input int sd, input mac_addr_t mac);
		logic [31:0] crc;
		exp_q.delete();
		repeat (7) exp_q.push_back(8'h55);
		exp_q.push_back(8'hD5);
		repeat (6) exp_q.push_back(8'hFF);
		for (int i = 5; i >= 0; i--)
			exp_q.push_back(mac[8*i +: 8]);
		exp_q.push_back(byte_t'(len >> 8));
		exp_q.push_back(byte_t'(len));
		for (int i = 0; i < len; i++)
			exp_q.push_back(byte_t'(sd + i));
		crc = '1;
		// CRC covers destination through payload but not the preamble
		for (int i = 8; i < exp_q.size(); i++)
			crc = crc_update(crc, exp_q[i]);
		crc = ~crc;
		for (int i = 0; i < 4; i++)
			exp_q.push_back(crc[8*i +: 8]);
	endtask

	// Collect every tx_en burst and measure the idle cycles between bursts
	always @(posedge tx_clk) begin
		if (gmii_tx_en) begin
			mon_bytes.push_back(gmii_txd);
			cur_len++;
			if (!prev_en) begin
				starts <= starts + 1;
				if (done_cnt > 0) begin
					assert (gap_len >= `ETH_IFG_CYCLES) else begin
						$display("ERROR %s gap: expected >= %0d, actual %0d",
							cur_test, `ETH_IFG_CYCLES, gap_len);
						err_cnt++;
					end
				end
			end
		end else if (prev_en) begin
			mon_lens.push_back(cur_len);
			cur_len = 0;
			gap_len = 1;
			done_cnt <= done_cnt + 1;
		end else begin
			gap_len++;
		end
		prev_en = gmii_tx_en;
	end

	// Called and returns on a rising edge
	task automatic send_write(input logic [7:0] addr, input axi_data_t data,
			output logic [1:0] resp);
		int dly;
		dly = rand_range(0, 5);
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		awaddr  <= addr;
		wdata   <= data;
		@(posedge tx_clk);
		while (!awready) @(posedge tx_clk);
		assert (wready) else begin
			$display("ERROR %s: wready was not raised together with awready", cur_test);
			err_cnt++;
		end
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		@(posedge tx_clk);
		while (!bvalid) @(posedge tx_clk);
		// Response must stay up while bready is held low
		repeat (dly) begin
			@(posedge tx_clk);
			assert (bvalid) else begin
				$display("ERROR %s: bvalid dropped before bready", cur_test);
				err_cnt++;
			end
		end
		bready <= 1'b1;
		@(posedge tx_clk);
		resp = bresp;
		bready <= 1'b0;
	endtask

	task automatic send_read(input logic [7:0] addr, output axi_data_t data,
			output logic [1:0] resp);
		int        dly;
		axi_data_t first;
		dly = rand_range(0, 5);
		arvalid <= 1'b1;
		araddr  <= addr;
		@(posedge tx_clk);
		while (!arready) @(posedge tx_clk);
		arvalid <= 1'b0;
		@(posedge tx_clk);
		while (!rvalid) @(posedge tx_clk);
		first = rdata;
		repeat (dly) begin
			@(posedge tx_clk);
			assert (rvalid && rdata == first) else begin
				$display("ERROR %s: rvalid or rdata changed before rready", cur_test);
				err_cnt++;
			end
		end
		rready <= 1'b1;
		@(posedge tx_clk);
		data = rdata;
		resp = rresp;
		rready <= 1'b0;
	endtask

	task automatic write_reg(input logic [7:0] addr, input axi_data_t data);
		logic [1:0] resp;
		send_write(addr, data, resp);
		assert (resp == 2'b00) else begin
			$display("ERROR %s bresp at %02h: expected 0, actual %0d", cur_test, addr, resp);
			err_cnt++;
		end
	endtask

	task automatic check_reg(input logic [7:0] addr, input axi_data_t expected);
		axi_data_t  data;
		logic [1:0] resp;
		send_read(addr, data, resp);
		assert (resp == 2'b00) else begin
			$display("ERROR %s rresp at %02h: expected 0, actual %0d", cur_test, addr, resp);
			err_cnt++;
		end
		assert (data == expected) else begin
			$display("ERROR %s reg %02h: expected %08h, actual %08h",
				cur_test, addr, expected, data);
			err_cnt++;
		end
	endtask

	task automatic wait_bursts(input int n);
		while (done_cnt < n) @(posedge tx_clk);
	endtask

	// Compare the oldest monitored burst with the model
	task automatic check_frame(input int len, input int sd, input mac_addr_t mac);
		int    act_len;
		byte_t b;
		bit    bad;
		build_frame(len, sd, mac);
		act_len = mon_lens.pop_front();
		bad     = 1'b0;
		assert (act_len == 26 + len) else begin
			$display("ERROR %s burst length: expected %0d, actual %0d",
				cur_test, 26 + len, act_len);
			err_cnt++;
		end
		for (int i = 0; i < act_len; i++) begin
			b = mon_bytes.pop_front();
			// Report only the first wrong byte of a burst
			if (!bad && i < exp_q.size()) begin
				assert (b == exp_q[i]) else begin
					$display("ERROR %s byte %0d: expected %02h, actual %02h",
						cur_test, i, exp_q[i], b);
					err_cnt++;
					bad = 1'b1;
				end
			end
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		err_base = err_cnt;
	endtask

	task automatic end_test();
		int errs;
		errs = err_cnt - err_base;
		if (errs == 0) begin
			$display("PASS %s", cur_test);
			n_pass++;
		end else begin
			$display("FAIL %s, %0d errors", cur_test, errs);
			n_fail++;
		end
	endtask

	initial begin
		logic [1:0] resp;
		axi_data_t  data;
		seed    = 18989;
		rst     = 1'b1;
		awvalid = 1'b0;
		awaddr  = '0;
		wvalid  = 1'b0;
		wdata   = '0;
		wstrb   = 4'hF;
		bready  = 1'b0;
		arvalid = 1'b0;
		araddr  = '0;
		rready  = 1'b0;
		len0  = rand_range(46, 200);
		seed0 = rand_range(0, 255);
		mac0  = rand_mac();
		for (int k = 0; k < 4; k++) begin
			shot_len[k]  = rand_range(46, 200);
			shot_seed[k] = rand_range(0, 255);
			shot_mac[k]  = rand_mac();
		end
		cont_len  = rand_range(46, 200);
		cont_seed = rand_range(0, 255);
		cont_mac  = rand_mac();
		// Burst plus gap per frame and a margin for AXI traffic and quiet windows
		wd_limit = 38 + len0 + 3 * (38 + cont_len) + 3000;
		for (int k = 0; k < 4; k++)
			wd_limit += 38 + shot_len[k];
		wd_limit = wd_limit * 10 * 2;

		repeat (16) @(posedge tx_clk);
		rst <= 1'b0;
		@(posedge tx_clk);

		start_test("reg_access");
		write_reg(`ETH_REG_LEN, 32'd10);
		check_reg(`ETH_REG_LEN, 32'd46);
		write_reg(`ETH_REG_LEN, 32'd3000);
		check_reg(`ETH_REG_LEN, 32'd1500);
		write_reg(`ETH_REG_MAC_LO, mac0[31:0]);
		check_reg(`ETH_REG_MAC_LO, mac0[31:0]);
		write_reg(`ETH_REG_MAC_HI, {16'b0, mac0[47:32]});
		check_reg(`ETH_REG_MAC_HI, {16'b0, mac0[47:32]});
		write_reg(`ETH_REG_SEED, axi_data_t'(seed0));
		check_reg(`ETH_REG_SEED, axi_data_t'(seed0));
		write_reg(`ETH_REG_LEN, axi_data_t'(len0));
		check_reg(`ETH_REG_LEN, axi_data_t'(len0));
		// Start bit requests one frame and never reads back
		write_reg(`ETH_REG_CTRL, 32'h2);
		check_reg(`ETH_REG_CTRL, 32'h0);
		exp_done++;
		wait_bursts(exp_done);
		check_frame(len0, seed0, mac0);
		end_test();

		start_test("unmapped_addr");
		send_write(8'h18, 32'hDEADBEEF, resp);
		assert (resp == 2'b10) else begin
			$display("ERROR %s bresp: expected 2, actual %0d", cur_test, resp);
			err_cnt++;
		end
		send_read(8'h40, data, resp);
		assert (resp == 2'b10) else begin
			$display("ERROR %s rresp: expected 2, actual %0d", cur_test, resp);
			err_cnt++;
		end
		assert (data == '0) else begin
			$display("ERROR %s rdata: expected 00000000, actual %08h", cur_test, data);
			err_cnt++;
		end
		end_test();

		start_test("handshake_delays");
		repeat (8) begin
			val = rand_range(0, 255);
			write_reg(`ETH_REG_SEED, axi_data_t'(val));
			check_reg(`ETH_REG_SEED, axi_data_t'(val));
		end
		end_test();

		start_test("single_shot");
		for (int k = 0; k < 4; k++) begin
			write_reg(`ETH_REG_LEN, axi_data_t'(shot_len[k]));
			write_reg(`ETH_REG_SEED, axi_data_t'(shot_seed[k]));
			write_reg(`ETH_REG_MAC_LO, shot_mac[k][31:0]);
			write_reg(`ETH_REG_MAC_HI, {16'b0, shot_mac[k][47:32]});
			write_reg(`ETH_REG_CTRL, 32'h2);
			exp_done++;
			wait_bursts(exp_done);
			check_frame(shot_len[k], shot_seed[k], shot_mac[k]);
		end
		end_test();

		start_test("continuous");
		write_reg(`ETH_REG_LEN, axi_data_t'(cont_len));
		write_reg(`ETH_REG_SEED, axi_data_t'(cont_seed));
		write_reg(`ETH_REG_MAC_LO, cont_mac[31:0]);
		write_reg(`ETH_REG_MAC_HI, {16'b0, cont_mac[47:32]});
		write_reg(`ETH_REG_CTRL, 32'h1);
		check_reg(`ETH_REG_CTRL, 32'h1);
		// Enable drops as the third burst rises while its frame is still being generated
		while (starts < exp_done + 3) @(posedge tx_clk);
		write_reg(`ETH_REG_CTRL, 32'h0);
		exp_done += 3;
		wait_bursts(exp_done);
		repeat (3) check_frame(cont_len, cont_seed, cont_mac);
		repeat (400) @(posedge tx_clk);
		assert (starts == exp_done) else begin
			$display("ERROR %s bursts after enable cleared: expected %0d, actual %0d",
				cur_test, exp_done, starts);
			err_cnt++;
		end
		end_test();

		start_test("frame_count");
		check_reg(`ETH_REG_COUNT, axi_data_t'(done_cnt));
		end_test();

		$display("Tests: %0d passed, %0d failed, %0d errors", n_pass, n_fail, err_cnt);
		if (n_fail == 0 && err_cnt == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	// Watchdog armed once the frame lengths are known
	initial begin
		wait (wd_limit != 0);
		#(wd_limit);
		$display("Timeout: the tests did not finish within %0d time units", wd_limit);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the GMII transmit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f vlog.f --top-module eth_test_tb -o eth_test_sim \
	&& ./obj_dir/eth_test_sim > sim.log 2>&1 \
	|| { echo "Build or simulation run error"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0

// ==== src/axil_ctrl_regs.sv ====
/* AXI4-Lite register block. One outstanding write and one outstanding read;
   wstrb is not honoured, every write updates the whole register. */
`default_nettype none
`include "eth_test_config.svh"

module axil_ctrl_regs import eth_test_pkg::*; (
	input  wire logic                       tx_clk,
	input  wire logic                       rst,
	input  wire logic                       awvalid,
	output logic                            awready,
	input  wire logic [`ETH_AXI_ADDR_W-1:0] awaddr,
	input  wire logic                       wvalid,
	output logic                            wready,
	input  wire axi_data_t                  wdata,
	input  wire logic [3:0]                 wstrb,
	output logic                            bvalid,
	input  wire logic                       bready,
	output logic [1:0]                      bresp,
	input  wire logic                       arvalid,
	output logic                            arready,
	input  wire logic [`ETH_AXI_ADDR_W-1:0] araddr,
	output logic                            rvalid,
	input  wire logic                       rready,
	output axi_data_t                       rdata,
	output logic [1:0]                      rresp,
	input  wire logic                       frame_done,
	output logic                            enable,
	output logic                            start_pulse,
	output len_t                            payload_len,
	output mac_addr_t                       src_mac,
	output byte_t                           seed,
	input  wire logic                       gen_busy
);

	logic       wr_hs;
	logic       start_req;
	frame_cnt_t frame_cnt;
	axi_data_t  rd_word;
	logic       rd_err;

	// Address and data accepted together, only with no response pending
	assign wr_hs   = awvalid && wvalid && !bvalid;
	assign awready = wr_hs;
	assign wready  = wr_hs;
	assign arready = arvalid && !rvalid;

	always_ff @(posedge tx_clk) begin
		if (rst) begin
			bvalid      <= 1'b0;
			bresp       <= 2'b00;
			enable      <= 1'b0;
			start_req   <= 1'b0;
			start_pulse <= 1'b0;
			payload_len <= len_t'(`ETH_MIN_PAYLOAD);
			src_mac     <= '0;
			seed        <= '0;
			frame_cnt   <= '0;
		end else begin
			start_pulse <= 1'b0;
			// Hand a pending request over once the generator is free
			// Skip the cycle right after a pulse, gen_busy lags by one
			if (start_req && !gen_busy && !start_pulse) begin
				start_pulse <= 1'b1;
				start_req   <= 1'b0;
			end
			if (frame_done)
				frame_cnt <= frame_cnt + 1'b1;
			if (bvalid && bready)
				bvalid <= 1'b0;
			if (wr_hs) begin
				bvalid <= 1'b1;
				bresp  <= 2'b00;
				case (awaddr)
					`ETH_REG_CTRL: begin
						enable <= wdata[0];
						// Start is a request only, never stored as a bit
						if (wdata[1])
							start_req <= 1'b1;
					end
					`ETH_REG_LEN: begin
						// Clamp into the legal payload range
						if (wdata < `ETH_MIN_PAYLOAD)
							payload_len <= len_t'(`ETH_MIN_PAYLOAD);
						else if (wdata > `ETH_MAX_PAYLOAD)
							payload_len <= len_t'(`ETH_MAX_PAYLOAD);
						else
							payload_len <= wdata[10:0];
					end
					`ETH_REG_MAC_LO: src_mac[31:0]  <= wdata;
					`ETH_REG_MAC_HI: src_mac[47:32] <= wdata[15:0];
					`ETH_REG_SEED:   seed           <= wdata[7:0];
					// Counter is read-only, write is accepted and dropped
					`ETH_REG_COUNT:  ;
					default:         bresp <= 2'b10;
				endcase
			end
		end
	end

	// Read data mux
	always_comb begin
		rd_word = '0;
		rd_err  = 1'b0;
		case (araddr)
			`ETH_REG_CTRL:   rd_word = {31'b0, enable};
			`ETH_REG_LEN:    rd_word = {21'b0, payload_len};
			`ETH_REG_MAC_LO: rd_word = src_mac[31:0];
			`ETH_REG_MAC_HI: rd_word = {16'b0, src_mac[47:32]};
			`ETH_REG_COUNT:  rd_word = frame_cnt;
			`ETH_REG_SEED:   rd_word = {24'b0, seed};
			default:         rd_err  = 1'b1;
		endcase
	end

	always_ff @(posedge tx_clk) begin
		if (rst) begin
			rvalid <= 1'b0;
		end else if (arready) begin
			rvalid <= 1'b1;
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

	// Data and response held with rvalid until taken
	always_ff @(posedge tx_clk) begin
		if (arready) begin
			rdata <= rd_word;
			rresp <= rd_err ? 2'b10 : 2'b00;
		end
	end

endmodule

`default_nettype wire

// ==== src/byte_fifo.sv ====
/* Single-clock FIFO of bytes with an end-of-frame flag.
   Head entry is visible without a read; a write when full or a read when empty is dropped. */
`default_nettype none
`include "eth_test_config.svh"

module byte_fifo import eth_test_pkg::*; (
	input  wire logic  tx_clk,
	input  wire logic  rst,
	input  wire logic  wr_en,
	input  wire byte_t wr_byte,
	input  wire logic  wr_last,
	output logic       full,
	input  wire logic  rd_en,
	output byte_t      rd_byte,
	output logic       rd_last,
	output logic       empty
);

	localparam int ADDR_W = $clog2(`ETH_FIFO_DEPTH);

	// Each entry is the last flag above the data byte
	logic [8:0]      mem [`ETH_FIFO_DEPTH];
	// Extra msb tells full from empty
	logic [ADDR_W:0] wr_ptr;
	logic [ADDR_W:0] rd_ptr;
	logic            do_wr;
	logic            do_rd;

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
	               (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	// Head of queue
	assign rd_byte = mem[rd_ptr[ADDR_W-1:0]][7:0];
	assign rd_last = mem[rd_ptr[ADDR_W-1:0]][8];

	always_ff @(posedge tx_clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			// Both pointers may move in the same cycle
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge tx_clk) begin
		if (do_wr)
			mem[wr_ptr[ADDR_W-1:0]] <= {wr_last, wr_byte};
	end

endmodule

`default_nettype wire

// ==== src/eth_test_config.svh ====
/* Build constants for the GMII transmit test subsystem.
   FIFO depth must stay a power of two; register addresses are byte offsets. */
`ifndef ETH_TEST_CONFIG_SVH
`define ETH_TEST_CONFIG_SVH

// Byte FIFO between generator and MAC
`define ETH_FIFO_DEPTH 32

// Payload length limits, in bytes
`define ETH_MIN_PAYLOAD 46
`define ETH_MAX_PAYLOAD 1500

// Idle cycles between frames on GMII
`define ETH_IFG_CYCLES 12

// AXI4-Lite address width
`define ETH_AXI_ADDR_W 8

// Register map
`define ETH_REG_CTRL   8'h00
`define ETH_REG_LEN    8'h04
`define ETH_REG_MAC_LO 8'h08
`define ETH_REG_MAC_HI 8'h0C
`define ETH_REG_COUNT  8'h10
`define ETH_REG_SEED   8'h14

`endif

// ==== src/eth_test_pkg.sv ====
/* Shared types for the transmit test path; lengths are payload bytes only. */
`default_nettype none

package eth_test_pkg;

	// One byte on the GMII data bus
	typedef logic [7:0] byte_t;

	// Payload length, up to 1500
	typedef logic [10:0] len_t;

	// Station address
	typedef logic [47:0] mac_addr_t;

	// Completed frame counter
	typedef logic [31:0] frame_cnt_t;

	// AXI4-Lite data word
	typedef logic [31:0] axi_data_t;

	// Frame generator FSM
	typedef enum logic [1:0] {
		GEN_IDLE,
		GEN_HDR,
		GEN_PAYLOAD
	} gen_state_e;

	// Transmit MAC FSM
	typedef enum logic [2:0] {
		MAC_IDLE,
		MAC_PRE,
		MAC_DATA,
		MAC_FCS,
		MAC_GAP
	} mac_state_e;

endpackage

`default_nettype wire

// ==== src/eth_test_top.sv ====
/* Transmit test subsystem, AXI4-Lite control in, GMII out on tx_clk.
   No receive path; DDR conversion and clocking live outside. */
`default_nettype none
`include "eth_test_config.svh"

module eth_test_top import eth_test_pkg::*; (
	input  wire logic                       tx_clk,
	input  wire logic                       rst,
	input  wire logic                       awvalid,
	output logic                            awready,
	input  wire logic [`ETH_AXI_ADDR_W-1:0] awaddr,
	input  wire logic                       wvalid,
	output logic                            wready,
	input  wire axi_data_t                  wdata,
	input  wire logic [3:0]                 wstrb,
	output logic                            bvalid,
	input  wire logic                       bready,
	output logic [1:0]                      bresp,
	input  wire logic                       arvalid,
	output logic                            arready,
	input  wire logic [`ETH_AXI_ADDR_W-1:0] araddr,
	output logic                            rvalid,
	input  wire logic                       rready,
	output axi_data_t                       rdata,
	output logic [1:0]                      rresp,
	output byte_t                           gmii_txd,
	output logic                            gmii_tx_en
);

	// Register block to generator
	logic      enable;
	logic      start_pulse;
	len_t      payload_len;
	mac_addr_t src_mac;
	byte_t     seed;
	logic      gen_busy;
	// Generator to FIFO
	logic      wr_en;
	byte_t     wr_byte;
	logic      wr_last;
	logic      full;
	// FIFO to MAC
	logic      rd_en;
	byte_t     rd_byte;
	logic      rd_last;
	logic      empty;
	// MAC back to the frame counter
	logic      frame_done;

	axil_ctrl_regs i_regs (
		.tx_clk, .rst,
		.awvalid, .awready, .awaddr,
		.wvalid, .wready, .wdata, .wstrb,
		.bvalid, .bready, .bresp,
		.arvalid, .arready, .araddr,
		.rvalid, .rready, .rdata, .rresp,
		.frame_done,
		.enable, .start_pulse, .payload_len, .src_mac, .seed,
		.gen_busy
	);

	frame_gen i_gen (
		.tx_clk, .rst,
		.enable, .start_pulse, .payload_len, .src_mac, .seed,
		.full,
		.wr_en, .wr_byte, .wr_last,
		.gen_busy
	);

	byte_fifo i_fifo (
		.tx_clk, .rst,
		.wr_en, .wr_byte, .wr_last, .full,
		.rd_en, .rd_byte, .rd_last, .empty
	);

	gmii_tx_mac i_mac (
		.tx_clk, .rst,
		.rd_byte, .rd_last, .empty, .rd_en,
		.gmii_txd, .gmii_tx_en,
		.frame_done
	);

endmodule

`default_nettype wire

// ==== src/frame_gen.sv ====
/* Test frame source. Configuration is sampled at frame start;
   once a frame is running it writes one byte per cycle whenever the FIFO has room. */
`default_nettype none

module frame_gen import eth_test_pkg::*; (
	input  wire logic      tx_clk,
	input  wire logic      rst,
	input  wire logic      enable,
	input  wire logic      start_pulse,
	input  wire len_t      payload_len,
	input  wire mac_addr_t src_mac,
	input  wire byte_t     seed,
	input  wire logic      full,
	output logic           wr_en,
	output byte_t          wr_byte,
	output logic           wr_last,
	output logic           gen_busy
);

	gen_state_e state;
	// Header byte index, then payload byte index
	len_t       idx;
	len_t       len_q;
	mac_addr_t  mac_q;
	byte_t      seed_q;
	byte_t      hdr_byte;

	assign gen_busy = (state != GEN_IDLE);
	assign wr_en    = gen_busy && !full;
	assign wr_last  = (state == GEN_PAYLOAD) && (idx == len_q - 1'b1);

	// Broadcast destination, source MAC msb first, then length
	always_comb begin
		case (idx[3:0])
			4'd6:    hdr_byte = mac_q[47:40];
			4'd7:    hdr_byte = mac_q[39:32];
			4'd8:    hdr_byte = mac_q[31:24];
			4'd9:    hdr_byte = mac_q[23:16];
			4'd10:   hdr_byte = mac_q[15:8];
			4'd11:   hdr_byte = mac_q[7:0];
			4'd12:   hdr_byte = {5'b0, len_q[10:8]};
			4'd13:   hdr_byte = len_q[7:0];
			default: hdr_byte = 8'hFF;
		endcase
	end

	// Payload counts up from the seed and wraps
	assign wr_byte = (state == GEN_PAYLOAD) ? seed_q + idx[7:0] : hdr_byte;

	always_ff @(posedge tx_clk) begin
		if (rst) begin
			state <= GEN_IDLE;
			idx   <= '0;
		end else begin
			case (state)
				GEN_IDLE: begin
					idx <= '0;
					if (start_pulse || enable)
						state <= GEN_HDR;
				end
				GEN_HDR: begin
					if (!full) begin
						if (idx == len_t'(13)) begin
							idx   <= '0;
							state <= GEN_PAYLOAD;
						end else begin
							idx <= idx + 1'b1;
						end
					end
				end
				GEN_PAYLOAD: begin
					if (!full) begin
						if (wr_last)
							state <= GEN_IDLE;
						else
							idx <= idx + 1'b1;
					end
				end
				default: state <= GEN_IDLE;
			endcase
		end
	end

	// Snapshot of the registers for the whole frame
	always_ff @(posedge tx_clk) begin
		if (state == GEN_IDLE) begin
			len_q  <= payload_len;
			mac_q  <= src_mac;
			seed_q <= seed;
		end
	end

endmodule

`default_nettype wire

// ==== src/gmii_tx_mac.sv ====
/* GMII framer. Expects the whole frame body to arrive without gaps once started;
   no padding and no tx_er, short frames must be padded upstream. */
`default_nettype none
`include "eth_test_config.svh"

module gmii_tx_mac import eth_test_pkg::*; (
	input  wire logic  tx_clk,
	input  wire logic  rst,
	input  wire byte_t rd_byte,
	input  wire logic  rd_last,
	input  wire logic  empty,
	output logic       rd_en,
	output byte_t      gmii_txd,
	output logic       gmii_tx_en,
	output logic       frame_done
);

	mac_state_e  state;
	// Preamble, FCS and gap counter
	logic [3:0]  cnt;
	logic [31:0] crc;
	logic [31:0] fcs;

	// One step of the reflected CRC-32, lsb first
	function automatic logic [31:0] crc32_byte(input logic [31:0] c_in, input byte_t d);
		logic [31:0] c;
		c = c_in ^ {24'b0, d};
		for (int i = 0; i < 8; i++) begin
			if (c[0])
				c = (c >> 1) ^ 32'hEDB88320;
			else
				c = c >> 1;
		end
		return c;
	endfunction

	// Pop the FIFO on every data cycle
	assign rd_en = (state == MAC_DATA);

	// FCS is the inverted remainder, low byte first
	assign fcs = ~crc;

	always_ff @(posedge tx_clk) begin
		if (rst) begin
			state      <= MAC_IDLE;
			cnt        <= '0;
			crc        <= '1;
			gmii_txd   <= '0;
			gmii_tx_en <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			case (state)
				MAC_IDLE: begin
					gmii_txd   <= '0;
					gmii_tx_en <= 1'b0;
					// First preamble byte goes out with the state change
					if (!empty) begin
						gmii_txd   <= 8'h55;
						gmii_tx_en <= 1'b1;
						cnt        <= 4'd1;
						crc        <= '1;
						state      <= MAC_PRE;
					end
				end
				MAC_PRE: begin
					// Six more 0x55, then the SFD
					if (cnt == 4'd7) begin
						gmii_txd <= 8'hD5;
						state    <= MAC_DATA;
					end else begin
						gmii_txd <= 8'h55;
						cnt      <= cnt + 1'b1;
					end
				end
				MAC_DATA: begin
					gmii_txd <= rd_byte;
					crc      <= crc32_byte(crc, rd_byte);
					if (rd_last) begin
						cnt   <= '0;
						state <= MAC_FCS;
					end
				end
				MAC_FCS: begin
					gmii_txd <= fcs[8*cnt[1:0] +: 8];
					if (cnt == 4'd3) begin
						cnt   <= '0;
						state <= MAC_GAP;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				MAC_GAP: begin
					gmii_txd   <= '0;
					gmii_tx_en <= 1'b0;
					// Reported in the cycle after the last FCS byte
					frame_done <= (cnt == 4'd0);
					if (cnt == 4'(`ETH_IFG_CYCLES - 1))
						state <= MAC_IDLE;
					else
						cnt <= cnt + 1'b1;
				end
				default: state <= MAC_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+src
src/eth_test_pkg.sv
src/axil_ctrl_regs.sv
src/frame_gen.sv
src/byte_fifo.sv
src/gmii_tx_mac.sv
src/eth_test_top.sv
dv/eth_test_tb.sv
